/* sources.f */
source/ecc_pkg.sv
source/mem_pkg.sv
source/secded_codec.sv
source/apb_port.sv
source/mem_arbiter.sv
source/ecc_memory.sv
source/ecc_mem_top.sv
verif/tb_checker.sv
verif/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := tb_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@! grep -q "Regression failed" $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_top.sv */
module tb_top;
    import ecc_pkg::*;
    import mem_pkg::*;

    localparam int n_transfers  = 400;
    localparam int reset_cycles = 16;
    localparam int max_cycles   = n_transfers * 8 + reset_cycles;
    localparam int region_words = mem_depth / 2;        // each port owns half the words

    logic     clk;
    logic     reset;
    apb_req_t apb_req [2];
    apb_rsp_t apb_rsp [2];
    int       issued [2];
    int       error_count;
    int       check_count;
    int       done_a;
    int       done_b;
    int       tb_errors;
    int       cycle_count;

    ecc_mem_top ecc_mem_top_inst (
        .clk       (clk),
        .reset     (reset),
        .apb_a_in  (apb_req[0]),
        .apb_a_out (apb_rsp[0]),
        .apb_b_in  (apb_req[1]),
        .apb_b_out (apb_rsp[1])
    );

    tb_checker checker_inst (
        .clk         (clk),
        .reset       (reset),
        .apb_a_req   (apb_req[0]),
        .apb_a_rsp   (apb_rsp[0]),
        .apb_b_req   (apb_req[1]),
        .apb_b_rsp   (apb_rsp[1]),
        .error_count (error_count),
        .check_count (check_count),
        .done_a      (done_a),
        .done_b      (done_b)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: transfers still running after %0d cycles", max_cycles);
        $display("Regression failed");
        $finish;
    end

    task automatic apb_transfer(input int p, input logic write, input apb_addr_t paddr,
                                input ecc_data_t wdata);
        @(posedge clk);
        #2;
        apb_req[p].psel    = 1'b1;                      // setup phase
        apb_req[p].penable = 1'b0;
        apb_req[p].pwrite  = write;
        apb_req[p].paddr   = paddr;
        apb_req[p].pwdata  = wdata;
        @(posedge clk);
        #2;
        apb_req[p].penable = 1'b1;
        do begin
            @(negedge clk);
        end while (!apb_rsp[p].pready);
        @(posedge clk);
        #2;
        apb_req[p].psel    = 1'b0;
        apb_req[p].penable = 1'b0;
        issued[p]++;
    endtask

    task automatic run_port(input int p);
        logic [region_words-1:0] written;
        int                      op;
        int                      idx;
        apb_addr_t               ctrl_addr;
        apb_addr_t               paddr;
        written   = '0;
        ctrl_addr = apb_addr_t'(1 << ctrl_bit);
        while (issued[p] < n_transfers) begin
            op    = int'($urandom % 16);
            idx   = int'($urandom % region_words);
            paddr = apb_addr_t'(p * region_words + idx);
            if (op < 2) begin
                apb_transfer(p, 1'b1, ctrl_addr, ecc_data_t'({$urandom, $urandom}));
            end else if (op == 2) begin
                apb_transfer(p, 1'b0, ctrl_addr, '0);
            end else if (op < 9 || !written[idx]) begin
                apb_transfer(p, 1'b1, paddr, ecc_data_t'({$urandom, $urandom}));
                written[idx] = 1'b1;
                if ($urandom % 2) begin
                    apb_transfer(p, 1'b0, paddr, '0);   // read back right away
                end
            end else begin
                apb_transfer(p, 1'b0, paddr, '0);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h3f3a));
        reset      = 1'b1;
        apb_req[0] = '0;
        apb_req[1] = '0;
        issued[0]  = 0;
        issued[1]  = 0;
        tb_errors  = 0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;
        fork
            run_port(0);
            run_port(1);
        join
        repeat (4) @(posedge clk);
        if (done_a != issued[0]) begin
            tb_errors++;
            $display("port a: checker saw %0d transfers, %0d were issued", done_a, issued[0]);
        end
        if (done_b != issued[1]) begin
            tb_errors++;
            $display("port b: checker saw %0d transfers, %0d were issued", done_b, issued[1]);
        end
        $display("checks %0d errors %0d transfer errors %0d", check_count, error_count,
                 tb_errors);
        if (error_count == 0 && tb_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verif/tb_checker.sv */
module tb_checker (
    input  logic              clk,
    input  logic              reset,
    input  mem_pkg::apb_req_t apb_a_req,
    input  mem_pkg::apb_rsp_t apb_a_rsp,
    input  mem_pkg::apb_req_t apb_b_req,
    input  mem_pkg::apb_rsp_t apb_b_rsp,
    output int                error_count,
    output int                check_count,
    output int                done_a,
    output int                done_b
);
    import ecc_pkg::*;
    import mem_pkg::*;

    ecc_data_t  model_data [mem_depth];
    ecc_code_t  model_flip [mem_depth];                 // flips stored with each word
    ecc_code_t  pending [2];
    err_count_t model_count [2];

    // control word fields to a codeword flip mask
    function automatic ecc_code_t inj_mask(ecc_data_t wd);
        ecc_code_t mask;
        int        pos_a;
        int        pos_b;
        mask  = '0;
        pos_a = int'(wd[inj_a_lsb +: inj_pos_width]);
        pos_b = int'(wd[inj_b_lsb +: inj_pos_width]);
        if (wd[inj_a_en] && pos_a < code_width) begin
            mask[pos_a] = 1'b1;
        end
        if (wd[inj_b_en] && pos_b < code_width) begin
            mask[pos_b] = 1'b1;                         // same position twice is one flip
        end
        return mask;
    endfunction

    task automatic compare(input string name, input int p, input ecc_data_t exp_val,
                           input ecc_data_t got_val);
        check_count++;
        if (exp_val !== got_val) begin
            error_count++;
            $display("mismatch %s port %0d exp %h got %h", name, p, exp_val, got_val);
        end
    endtask

    task automatic record_transfer(input int p, input apb_req_t req, input apb_rsp_t rsp);
        mem_word_addr_t addr;
        ecc_code_t      flips;
        ecc_data_t      exp_data;
        logic           exp_err;
        addr = req.paddr[addr_width-1:0];
        if (req.paddr[ctrl_bit]) begin
            if (req.pwrite) begin
                pending[p] = inj_mask(req.pwdata);
            end else begin
                compare("prdata", p, ecc_data_t'(model_count[p]), rsp.prdata);
            end
            compare("pslverr", p, '0, ecc_data_t'(rsp.pslverr));
        end else if (req.pwrite) begin
            model_data[addr] = req.pwdata;
            model_flip[addr] = pending[p];
            pending[p]       = '0;                      // only the next data write
            compare("pslverr", p, '0, ecc_data_t'(rsp.pslverr));
        end else begin
            flips    = model_flip[addr];
            exp_err  = ($countones(flips) == 2);
            exp_data = exp_err ? model_data[addr] ^ flips[data_width-1:0] : model_data[addr];
            if ($countones(flips) == 1 && model_count[p] != '1) begin
                model_count[p] = model_count[p] + 1'b1;
            end
            compare("prdata", p, exp_data, rsp.prdata);
            compare("pslverr", p, ecc_data_t'(exp_err), ecc_data_t'(rsp.pslverr));
        end
        if (p == 0) begin
            done_a++;
        end else begin
            done_b++;
        end
    endtask

    // pready is settled by the falling edge
    always @(negedge clk) begin
        if (reset) begin
            error_count = 0;
            check_count = 0;
            done_a      = 0;
            done_b      = 0;
            pending[0]  = '0;
            pending[1]  = '0;
            model_count[0] = '0;
            model_count[1] = '0;
        end else begin
            if (apb_a_req.psel && apb_a_req.penable && apb_a_rsp.pready) begin
                record_transfer(0, apb_a_req, apb_a_rsp);
            end
            if (apb_b_req.psel && apb_b_req.penable && apb_b_rsp.pready) begin
                record_transfer(1, apb_b_req, apb_b_rsp);
            end
        end
    end

endmodule

/* source/ecc_mem_top.sv */
module ecc_mem_top (
    input  logic              clk,
    input  logic              reset,
    input  mem_pkg::apb_req_t apb_a_in,
    output mem_pkg::apb_rsp_t apb_a_out,
    input  mem_pkg::apb_req_t apb_b_in,
    output mem_pkg::apb_rsp_t apb_b_out
);
    import mem_pkg::*;

    mem_req_t req_a;
    mem_req_t req_b;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    mem_rsp_t rsp_a;
    mem_rsp_t rsp_b;
    logic     grant_a;
    logic     grant_b;

    apb_port port_a_inst (
        .clk     (clk),
        .reset   (reset),
        .apb_in  (apb_a_in),
        .apb_out (apb_a_out),
        .mem_req (req_a),
        .grant   (grant_a),
        .mem_rsp (rsp_a)
    );

    apb_port port_b_inst (
        .clk     (clk),
        .reset   (reset),
        .apb_in  (apb_b_in),
        .apb_out (apb_b_out),
        .mem_req (req_b),
        .grant   (grant_b),
        .mem_rsp (rsp_b)
    );

    mem_arbiter arbiter_inst (
        .clk        (clk),
        .reset      (reset),
        .req_a      (req_a),
        .req_b      (req_b),
        .grant_a    (grant_a),
        .grant_b    (grant_b),
        .mem_req    (mem_req),
        .mem_rsp_in (mem_rsp),
        .rsp_a      (rsp_a),
        .rsp_b      (rsp_b)
    );

    ecc_memory memory_inst (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

/* source/ecc_memory.sv */
module ecc_memory (
    input  logic              clk,
    input  logic              reset,
    input  mem_pkg::mem_req_t mem_req,
    output mem_pkg::mem_rsp_t mem_rsp
);
    import ecc_pkg::*;
    import mem_pkg::*;

    ecc_code_t  mem_array [mem_depth];
    ecc_code_t  rd_word;
    ecc_data_t  codec_data;
    ecc_check_t check_gen;
    ecc_data_t  data_fix;
    logic       single_err;
    logic       double_err;
    logic       rd_en;
    logic       rsp_valid;
    ecc_data_t  rsp_data;
    logic       rsp_single;
    logic       rsp_double;

    assign rd_word    = mem_array[mem_req.addr];
    assign codec_data = mem_req.write ? mem_req.wdata : rd_word[data_width-1:0];
    assign rd_en      = mem_req.valid && !mem_req.write;

    secded_codec codec_inst (
        .data       (codec_data),
        .check      (rd_word[code_width-1:data_width]),
        .check_gen  (check_gen),
        .data_fix   (data_fix),
        .single_err (single_err),
        .double_err (double_err)
    );

    always_ff @(posedge clk) begin
        if (mem_req.valid && mem_req.write) begin
            mem_array[mem_req.addr] <= {check_gen, mem_req.wdata} ^ mem_req.flip;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rsp_data   <= data_fix;                     // corrected unless double error
            rsp_single <= single_err;
            rsp_double <= double_err;
        end
    end

    assign mem_rsp = '{valid: rsp_valid, rdata: rsp_data,
                       single_err: rsp_single, double_err: rsp_double};

endmodule

/* source/mem_arbiter.sv */
module mem_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  mem_pkg::mem_req_t req_a,
    input  mem_pkg::mem_req_t req_b,
    output logic              grant_a,
    output logic              grant_b,
    output mem_pkg::mem_req_t mem_req,
    input  mem_pkg::mem_rsp_t mem_rsp_in,
    output mem_pkg::mem_rsp_t rsp_a,
    output mem_pkg::mem_rsp_t rsp_b
);
    import mem_pkg::*;

    logic last_b;                                       // port b won the last grant
    logic owner_b;                                      // read in flight belongs to b

    always_comb begin
        grant_a = 1'b0;
        grant_b = 1'b0;
        if (req_a.valid && req_b.valid) begin
            grant_a = last_b;
            grant_b = !last_b;
        end else begin
            grant_a = req_a.valid;
            grant_b = req_b.valid;
        end
    end

    assign mem_req = grant_b ? req_b : req_a;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_b  <= 1'b0;
            owner_b <= 1'b0;
        end else if (grant_a || grant_b) begin
            last_b <= grant_b;
            if (!mem_req.write) begin
                owner_b <= grant_b;
            end
        end
    end

    always_comb begin
        rsp_a       = mem_rsp_in;
        rsp_b       = mem_rsp_in;
        rsp_a.valid = mem_rsp_in.valid && !owner_b;
        rsp_b.valid = mem_rsp_in.valid && owner_b;
    end

    // a port that loses arbitration is served in the next cycle
    grant_next_a: assert property (@(posedge clk) disable iff (reset)
        req_a.valid && !grant_a |=> grant_a)
        else $error("port a not granted after losing arbitration");

    grant_next_b: assert property (@(posedge clk) disable iff (reset)
        req_b.valid && !grant_b |=> grant_b)
        else $error("port b not granted after losing arbitration");

endmodule

/* source/apb_port.sv */
module apb_port (
    input  logic              clk,
    input  logic              reset,
    input  mem_pkg::apb_req_t apb_in,
    output mem_pkg::apb_rsp_t apb_out,
    output mem_pkg::mem_req_t mem_req,
    input  logic              grant,
    input  mem_pkg::mem_rsp_t mem_rsp
);
    import ecc_pkg::*;
    import mem_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_grant,
        st_wait_rsp
    } port_state_t;

    port_state_t state;
    logic        access;
    logic        ctrl_sel;
    logic        data_req;
    logic        wr_grant;
    logic        rsp_done;
    logic        ready_q;
    logic        slverr_q;
    ecc_data_t   rdata_q;
    ecc_code_t   flip_q;
    ecc_code_t   flip_next;
    err_count_t  err_count;

    function automatic ecc_code_t pos_to_mask(logic en, inj_pos_t pos);
        ecc_code_t mask;
        mask = '0;
        if (en && pos < code_width) begin               // out of range positions ignored
            mask[pos] = 1'b1;
        end
        return mask;
    endfunction

    assign access   = apb_in.psel && apb_in.penable;
    assign ctrl_sel = apb_in.paddr[ctrl_bit];
    assign data_req = access && !ctrl_sel && !ready_q && (state != st_wait_rsp);
    assign wr_grant = data_req && grant && apb_in.pwrite;
    assign rsp_done = (state == st_wait_rsp) && mem_rsp.valid;

    assign flip_next = pos_to_mask(apb_in.pwdata[inj_a_en], apb_in.pwdata[inj_a_lsb +: inj_pos_width])
                     | pos_to_mask(apb_in.pwdata[inj_b_en], apb_in.pwdata[inj_b_lsb +: inj_pos_width]);

    always_comb begin
        mem_req.valid = data_req;
        mem_req.write = apb_in.pwrite;
        mem_req.addr  = apb_in.paddr[addr_width-1:0];
        mem_req.wdata = apb_in.pwdata;
        mem_req.flip  = apb_in.pwrite ? flip_q : '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= st_idle;
            ready_q  <= 1'b0;
            slverr_q <= 1'b0;
        end else begin
            ready_q <= 1'b0;
            case (state)
                st_idle, st_wait_grant: begin
                    if (wr_grant) begin
                        ready_q  <= 1'b1;               // write done in grant cycle
                        slverr_q <= 1'b0;
                        state    <= st_idle;
                    end else if (data_req && grant) begin
                        state <= st_wait_rsp;
                    end else if (data_req) begin
                        state <= st_wait_grant;
                    end
                end
                st_wait_rsp: begin
                    if (mem_rsp.valid) begin
                        ready_q  <= 1'b1;
                        slverr_q <= mem_rsp.double_err;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_done) begin
            rdata_q <= mem_rsp.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flip_q    <= '0;
            err_count <= '0;
        end else begin
            if (access && ctrl_sel && apb_in.pwrite) begin
                flip_q <= flip_next;
            end else if (wr_grant) begin
                flip_q <= '0;                           // one shot
            end
            if (rsp_done && mem_rsp.single_err && err_count != '1) begin
                err_count <= err_count + 1'b1;
            end
        end
    end

    always_comb begin
        if (access && ctrl_sel) begin
            apb_out.pready  = 1'b1;
            apb_out.prdata  = ecc_data_t'(err_count);
            apb_out.pslverr = 1'b0;
        end else begin
            apb_out.pready  = ready_q;
            apb_out.prdata  = rdata_q;
            apb_out.pslverr = slverr_q;
        end
    end

    pready_in_access: assert property (@(posedge clk) disable iff (reset)
        apb_out.pready |-> access)
        else $error("pready outside an APB access phase");

endmodule

/* source/secded_codec.sv */
module secded_codec (
    input  ecc_pkg::ecc_data_t  data,
    input  ecc_pkg::ecc_check_t check,
    output ecc_pkg::ecc_check_t check_gen,
    output ecc_pkg::ecc_data_t  data_fix,
    output logic                single_err,
    output logic                double_err
);
    import ecc_pkg::*;

    ecc_syndrome_t syndrome;
    ecc_data_t     fix_mask;
    logic          check_hit;

    // syndrome produced by a flip of data bit bit_idx
    function automatic ecc_syndrome_t column(int bit_idx);
        ecc_syndrome_t col;
        for (int c = 0; c < check_width; c++) begin
            col[c] = check_mask[c][bit_idx];
        end
        return col;
    endfunction

    always_comb begin
        for (int c = 0; c < check_width; c++) begin
            check_gen[c] = ^(data & check_mask[c]);     // even parity over selected bits
        end
    end

    assign syndrome = check ^ check_gen;

    always_comb begin
        fix_mask = '0;
        for (int b = 0; b < data_width; b++) begin
            fix_mask[b] = (syndrome == column(b));
        end
    end

    assign check_hit = $onehot(syndrome);               // flip in a check bit only

    assign data_fix   = data ^ fix_mask;
    assign single_err = (fix_mask != '0) || check_hit;
    assign double_err = (syndrome != '0) && (fix_mask == '0) && !check_hit;

    // the column table must keep every syndrome unambiguous
    always_comb begin
        assert ($onehot0({check_hit, fix_mask}))
        else $error("secded syndrome decodes to more than one bit position");
    end

endmodule

/* source/mem_pkg.sv */
package mem_pkg;

    localparam int mem_depth       = 64;
    localparam int addr_width      = $clog2(mem_depth);
    localparam int apb_addr_width  = addr_width + 1;
    localparam int err_count_width = 16;

    // control word layout
    localparam int ctrl_bit      = addr_width;          // paddr bit selecting the control word
    localparam int inj_pos_width = 6;
    localparam int inj_a_lsb     = 0;
    localparam int inj_a_en      = 6;
    localparam int inj_b_lsb     = 8;
    localparam int inj_b_en      = 14;

    typedef logic [addr_width-1:0]      mem_word_addr_t;
    typedef logic [apb_addr_width-1:0]  apb_addr_t;
    typedef logic [err_count_width-1:0] err_count_t;
    typedef logic [inj_pos_width-1:0]   inj_pos_t;

    typedef struct packed {
        logic               psel;
        logic               penable;
        logic               pwrite;
        apb_addr_t          paddr;
        ecc_pkg::ecc_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        logic               pready;
        ecc_pkg::ecc_data_t prdata;
        logic               pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic               valid;
        logic               write;
        mem_word_addr_t     addr;
        ecc_pkg::ecc_data_t wdata;
        ecc_pkg::ecc_code_t flip;                       // xor'ed into the stored codeword
    } mem_req_t;

    typedef struct packed {
        logic               valid;
        ecc_pkg::ecc_data_t rdata;
        logic               single_err;
        logic               double_err;
    } mem_rsp_t;

endpackage

/* source/ecc_pkg.sv */
package ecc_pkg;

    localparam int data_width  = 45;
    localparam int check_width = 7;
    localparam int code_width  = data_width + check_width;

    typedef logic [data_width-1:0]  ecc_data_t;
    typedef logic [check_width-1:0] ecc_check_t;
    typedef logic [check_width-1:0] ecc_syndrome_t;    // stored check ^ recomputed check
    typedef logic [code_width-1:0]  ecc_code_t;        // {check, data}

    // Each entry lists the data bits that feed one check bit.
    // Column b across all entries is the syndrome of a flip in data bit b.
    localparam ecc_data_t check_mask [check_width] = '{
        45'h1555_56AA_AD5B,                             // p0
        45'h1999_9B33_366D,                             // p1
        45'h01E1_E3C3_C78E,                             // p2
        45'h01FE_03FC_07F0,                             // p3
        45'h1E00_03FF_F800,                             // p4
        45'h1FFF_FC00_0000,                             // p5
        45'h12D3_2DA6_5CB7                              // p6
    };

endpackage
